//--- project.f
hdl/mem_types_pkg.sv
hdl/plat_types_pkg.sv
hdl/reset_resync.sv
hdl/host_mmio_bridge.sv
hdl/copy_engine.sv
hdl/wb_arbiter.sv
hdl/local_mem_bridge.sv
hdl/green_shell.sv
sim/tb_green_shell.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the green shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_green_shell -f project.f

sim_out=$(./obj_dir/Vtb_green_shell)
echo "$sim_out"

# Pass only if the testbench printed the pass line
if echo "$sim_out" | grep -qx "Test OK"; then
   exit 0
else
   exit 1
fi

//--- sim/tb_green_shell.sv
// Testbench for the green region shell
// Table-driven host and copy traffic checked against a reference memory model
`timescale 1ns/1ps

module tb_green_shell;

   import plat_types_pkg::*;
   import mem_types_pkg::*;

   // Cycles allowed for any single wait
   localparam int TIMEOUT = 200;
   localparam int N_TESTS = 16;

   typedef enum logic [1:0] {
      T_HWRITE,
      T_HREAD,
      T_COPY,
      T_COPY_HOST
   } test_kind_e;

   // One table row holding the host address or the base of the host region
   typedef struct packed {
      test_kind_e            kind;
      logic [MEM_ADDR_W-1:0] adr;
      logic [MEM_SEL_W-1:0]  sel;
      copy_cmd_t             cmd;
   } test_entry_t;

   logic      Clk_100;
   logic      rst_n;
   host_req_t host_req;
   logic      host_req_valid;
   logic      host_req_ready;
   host_rsp_t host_rsp;
   copy_cmd_t copy_cmd;
   logic      copy_cmd_valid;
   logic      copy_cmd_ready;
   logic      copy_done;

   // Reference memory indexed by word address
   logic [MEM_DATA_W-1:0] ref_mem [MEM_DEPTH];
   string                 test_name [N_TESTS];
   test_entry_t           test_tab [N_TESTS];
   int                    mismatch_count;
   int                    timeout_count;
   int                    done_count;

   green_shell dut_i (
      .Clk_100        (Clk_100),
      .rst_n          (rst_n),
      .host_req       (host_req),
      .host_req_valid (host_req_valid),
      .host_req_ready (host_req_ready),
      .host_rsp       (host_rsp),
      .copy_cmd       (copy_cmd),
      .copy_cmd_valid (copy_cmd_valid),
      .copy_cmd_ready (copy_cmd_ready),
      .copy_done      (copy_done)
   );

   // 40 ns clock
   initial
   begin
      Clk_100 = 1'b0;
      forever #20 Clk_100 = ~Clk_100;
   end

   // Done pulses counted mid-cycle away from the edges
   always @(negedge Clk_100)
   begin
      if (copy_done === 1'b1)
         done_count++;
   end

   // ============================================================
   // Helpers
   // ============================================================

   // All driving happens 2 ns after the rising edge
   task automatic step_cycle();
      @(posedge Clk_100);
      #2;
   endtask

   // Selected byte lanes of the new word replace the old ones
   function automatic logic [MEM_DATA_W-1:0] merge_bytes(input logic [MEM_DATA_W-1:0] old_word,
                                                         input logic [MEM_DATA_W-1:0] new_word,
                                                         input logic [MEM_SEL_W-1:0]  sel);
      logic [MEM_DATA_W-1:0] res;
      res = old_word;
      for (int b = 0; b < MEM_SEL_W; b++)
      begin
         if (sel[b])
            res[b*8 +: 8] = new_word[b*8 +: 8];
      end
      return res;
   endfunction

   task automatic check_word(input string name, input logic [MEM_ADDR_W-1:0] adr,
                             input logic [MEM_DATA_W-1:0] exp,
                             input logic [MEM_DATA_W-1:0] act);
      if (act !== exp)
      begin
         mismatch_count++;
         $display("Mismatch in %s at adr %h: expected %h, actual %h", name, adr, exp, act);
      end
   endtask

   // One host request from ready to the response strobe
   task automatic host_access(input string name, input host_op_e op,
                              input logic [MEM_ADDR_W-1:0] adr,
                              input logic [MEM_DATA_W-1:0] dat,
                              input logic [MEM_SEL_W-1:0] sel,
                              output logic [MEM_DATA_W-1:0] rdata, output bit ok);
      int waited;
      ok     = 1'b0;
      rdata  = '0;
      waited = 0;
      while (host_req_ready !== 1'b1 && waited < TIMEOUT)
      begin
         step_cycle();
         waited++;
      end
      if (host_req_ready !== 1'b1)
      begin
         timeout_count++;
         $display("Timeout in %s: host_req_ready never went high", name);
         return;
      end
      host_req.op    = op;
      host_req.adr   = adr;
      host_req.dat   = dat;
      host_req.sel   = sel;
      host_req_valid = 1'b1;
      // Accepted on this edge since ready was high
      step_cycle();
      host_req_valid = 1'b0;
      waited = 0;
      while (host_rsp.valid !== 1'b1 && waited < TIMEOUT)
      begin
         step_cycle();
         waited++;
      end
      if (host_rsp.valid !== 1'b1)
      begin
         timeout_count++;
         $display("Timeout in %s: no host response for adr %h", name, adr);
         return;
      end
      rdata = host_rsp.dat;
      ok    = 1'b1;
   endtask

   // Write that expects zero response data and then updates the model
   task automatic host_write(input string name, input logic [MEM_ADDR_W-1:0] adr,
                             input logic [MEM_DATA_W-1:0] dat, input logic [MEM_SEL_W-1:0] sel);
      logic [MEM_DATA_W-1:0] rdata;
      bit                    ok;
      host_access(name, HOST_WRITE, adr, dat, sel, rdata, ok);
      if (ok)
      begin
         check_word(name, adr, '0, rdata);
         ref_mem[adr] = merge_bytes(ref_mem[adr], dat, sel);
      end
   endtask

   task automatic host_read_check(input string name, input logic [MEM_ADDR_W-1:0] adr);
      logic [MEM_DATA_W-1:0] rdata;
      bit                    ok;
      host_access(name, HOST_READ, adr, '0, '0, rdata, ok);
      if (ok)
         check_word(name, adr, ref_mem[adr], rdata);
   endtask

   // Issue a copy command and wait for its done pulse
   task automatic run_copy(input string name, input copy_cmd_t cmd);
      int                    waited;
      logic [MEM_ADDR_W-1:0] src_a;
      logic [MEM_ADDR_W-1:0] dst_a;
      waited = 0;
      while (copy_cmd_ready !== 1'b1 && waited < TIMEOUT)
      begin
         step_cycle();
         waited++;
      end
      if (copy_cmd_ready !== 1'b1)
      begin
         timeout_count++;
         $display("Timeout in %s: copy_cmd_ready never went high", name);
         return;
      end
      copy_cmd       = cmd;
      copy_cmd_valid = 1'b1;
      step_cycle();
      copy_cmd_valid = 1'b0;
      waited = 0;
      // A zero count may already show done here
      while (copy_done !== 1'b1 && waited < TIMEOUT)
      begin
         step_cycle();
         waited++;
      end
      if (copy_done !== 1'b1)
      begin
         timeout_count++;
         $display("Timeout in %s: copy_done never pulsed", name);
         return;
      end
      // Model moves words in address order as the copy does
      src_a = cmd.src_adr;
      dst_a = cmd.dst_adr;
      for (int i = 0; i < int'(cmd.count); i++)
      begin
         ref_mem[dst_a] = ref_mem[src_a];
         src_a++;
         dst_a++;
      end
   endtask

   // Host traffic to its own region while a copy runs
   task automatic host_traffic(input string name, input logic [MEM_ADDR_W-1:0] base);
      logic [MEM_ADDR_W-1:0] a;
      a = base;
      for (int i = 0; i < 4; i++)
      begin
         host_write(name, a, $urandom, 4'hF);
         host_read_check(name, a);
         a++;
      end
   endtask

   task automatic add_test(input int idx, input string name, input test_kind_e kind,
                           input logic [7:0] adr, input logic [3:0] sel,
                           input logic [7:0] src, input logic [7:0] dst, input logic [7:0] cnt);
      test_name[idx]             = name;
      test_tab[idx].kind         = kind;
      test_tab[idx].adr          = adr;
      test_tab[idx].sel          = sel;
      test_tab[idx].cmd.src_adr  = src;
      test_tab[idx].cmd.dst_adr  = dst;
      test_tab[idx].cmd.count    = cnt;
   endtask

   task automatic apply_test(input int idx);
      test_entry_t           t;
      string                 name;
      logic [MEM_ADDR_W-1:0] a;
      int                    n;
      int                    done_before;
      t    = test_tab[idx];
      name = test_name[idx];
      case (t.kind)
         T_HWRITE:
            host_write(name, t.adr, $urandom, t.sel);
         T_HREAD:
            host_read_check(name, t.adr);
         default:
         begin
            // Source words get known contents first
            a = t.cmd.src_adr;
            for (int i = 0; i < int'(t.cmd.count); i++)
            begin
               host_write(name, a, $urandom, 4'hF);
               a++;
            end
            done_before = done_count;
            if (t.kind == T_COPY_HOST)
            begin
               fork
                  run_copy(name, t.cmd);
                  host_traffic(name, t.adr);
               join
            end
            else
            begin
               run_copy(name, t.cmd);
            end
            // Zero count still reads one destination word that must stay unchanged
            n = (t.cmd.count == '0) ? 1 : int'(t.cmd.count);
            a = t.cmd.dst_adr;
            for (int i = 0; i < n; i++)
            begin
               host_read_check(name, a);
               a++;
            end
            if (done_count - done_before != 1)
            begin
               mismatch_count++;
               $display("Mismatch in %s: expected 1 copy_done pulse, actual %0d",
                        name, done_count - done_before);
            end
         end
      endcase
   endtask

   // ============================================================
   // Main sequence
   // ============================================================

   initial
   begin
      int waited;
      void'($urandom(32'hc630));
      rst_n          = 1'b0;
      host_req       = '0;
      host_req_valid = 1'b0;
      copy_cmd       = '0;
      copy_cmd_valid = 1'b0;
      mismatch_count = 0;
      timeout_count  = 0;
      done_count     = 0;

      add_test(0,  "wr_full_10",     T_HWRITE,    8'h10, 4'hF, 8'h00, 8'h00, 8'd0);
      add_test(1,  "rd_full_10",     T_HREAD,     8'h10, 4'hF, 8'h00, 8'h00, 8'd0);
      add_test(2,  "wr_full_11",     T_HWRITE,    8'h11, 4'hF, 8'h00, 8'h00, 8'd0);
      add_test(3,  "wr_part_11_lo",  T_HWRITE,    8'h11, 4'h3, 8'h00, 8'h00, 8'd0);
      add_test(4,  "rd_part_11_lo",  T_HREAD,     8'h11, 4'hF, 8'h00, 8'h00, 8'd0);
      add_test(5,  "wr_part_11_mix", T_HWRITE,    8'h11, 4'hA, 8'h00, 8'h00, 8'd0);
      add_test(6,  "rd_part_11_mix", T_HREAD,     8'h11, 4'hF, 8'h00, 8'h00, 8'd0);
      add_test(7,  "wr_full_ff",     T_HWRITE,    8'hFF, 4'hF, 8'h00, 8'h00, 8'd0);
      add_test(8,  "wr_part_ff_b2",  T_HWRITE,    8'hFF, 4'h4, 8'h00, 8'h00, 8'd0);
      add_test(9,  "rd_part_ff_b2",  T_HREAD,     8'hFF, 4'hF, 8'h00, 8'h00, 8'd0);
      add_test(10, "copy_4",         T_COPY,      8'h00, 4'hF, 8'h20, 8'h40, 8'd4);
      add_test(11, "copy_zero",      T_COPY,      8'h00, 4'hF, 8'h20, 8'h10, 8'd0);
      add_test(12, "copy_1",         T_COPY,      8'h00, 4'hF, 8'h30, 8'h31, 8'd1);
      add_test(13, "copy_host_6",    T_COPY_HOST, 8'hA0, 4'hF, 8'h60, 8'h80, 8'd6);
      add_test(14, "copy_host_10",   T_COPY_HOST, 8'h50, 4'hF, 8'hC0, 8'hD0, 8'd10);
      add_test(15, "rd_after_copy",  T_HREAD,     8'h42, 4'hF, 8'h00, 8'h00, 8'd0);

      repeat (8) @(posedge Clk_100);
      #2;
      rst_n = 1'b1;

      // Outputs stay quiet through the reset release
      // Internal reset is released RST_SYNC_LEN edges after rst_n
      waited = 0;
      forever
      begin
         if (host_rsp.valid !== 1'b0 || copy_done !== 1'b0)
         begin
            mismatch_count++;
            $display("Mismatch in reset: expected valid 0 done 0, actual valid %b done %b",
                     host_rsp.valid, copy_done);
         end
         if ((host_req_ready === 1'b1 && copy_cmd_ready === 1'b1 && waited > RST_SYNC_LEN) ||
             waited >= TIMEOUT)
            break;
         step_cycle();
         waited++;
      end
      if (host_req_ready !== 1'b1 || copy_cmd_ready !== 1'b1)
      begin
         timeout_count++;
         $display("Timeout after reset: host_req_ready or copy_cmd_ready stayed low");
      end

      for (int i = 0; i < N_TESTS; i++)
         apply_test(i);

      $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

//--- hdl/green_shell.sv
// Green region shell
// Connects host bridge and copy engine to one local memory bank over a shared bus
`timescale 1ns/1ps

module green_shell
(
   input  logic                      Clk_100,
   input  logic                      rst_n,
   // Host channel
   input  plat_types_pkg::host_req_t host_req,
   input  logic                      host_req_valid,
   output logic                      host_req_ready,
   output plat_types_pkg::host_rsp_t host_rsp,
   // Accelerator command channel
   input  plat_types_pkg::copy_cmd_t copy_cmd,
   input  logic                      copy_cmd_valid,
   output logic                      copy_cmd_ready,
   output logic                      copy_done
);

   import mem_types_pkg::*;

   logic    rst_sync_n;
   // m0 is the host bridge, m1 the copy engine
   wb_req_t m0_req;
   wb_rsp_t m0_rsp;
   wb_req_t m1_req;
   wb_rsp_t m1_rsp;
   wb_req_t s_req;
   wb_rsp_t s_rsp;

   // ============================================================
   // Reset
   // ============================================================

   reset_resync rst_sync_i (
      .Clk_100    (Clk_100),
      .rst_n      (rst_n),
      .rst_sync_n (rst_sync_n)
   );

   // ============================================================
   // Bus masters
   // ============================================================

   host_mmio_bridge host_bridge_i (
      .Clk_100        (Clk_100),
      .rst_n          (rst_sync_n),
      .host_req       (host_req),
      .host_req_valid (host_req_valid),
      .host_req_ready (host_req_ready),
      .host_rsp       (host_rsp),
      .wb_m           (m0_req),
      .wb_s           (m0_rsp)
   );

   copy_engine copy_i (
      .Clk_100        (Clk_100),
      .rst_n          (rst_sync_n),
      .copy_cmd       (copy_cmd),
      .copy_cmd_valid (copy_cmd_valid),
      .copy_cmd_ready (copy_cmd_ready),
      .copy_done      (copy_done),
      .wb_m           (m1_req),
      .wb_s           (m1_rsp)
   );

   // ============================================================
   // Shared bus and memory bank
   // ============================================================

   wb_arbiter arb_i (
      .Clk_100 (Clk_100),
      .rst_n   (rst_sync_n),
      .m0_req  (m0_req),
      .m1_req  (m1_req),
      .m0_rsp  (m0_rsp),
      .m1_rsp  (m1_rsp),
      .s_req   (s_req),
      .s_rsp   (s_rsp)
   );

   local_mem_bridge mem_i (
      .Clk_100 (Clk_100),
      .rst_n   (rst_sync_n),
      .s_req   (s_req),
      .s_rsp   (s_rsp)
   );

endmodule

//--- hdl/local_mem_bridge.sv
// Local memory bridge
// Wishbone slave, request register in front of the on-chip word array
`timescale 1ns/1ps

module local_mem_bridge
(
   input  logic                   Clk_100,
   input  logic                   rst_n,
   input  mem_types_pkg::wb_req_t s_req,
   output mem_types_pkg::wb_rsp_t s_rsp
);

   import mem_types_pkg::*;

   // Memory bank, contents survive reset
   logic [MEM_DATA_W-1:0] mem [MEM_DEPTH];

   // Pipeline stage holding the captured request
   wb_req_t               req_q;
   logic                  pend_q;
   logic                  ack_q;
   logic [MEM_DATA_W-1:0] dat_q;
   logic                  take;

   // ============================================================
   // Request capture
   // ============================================================

   // No capture while busy or during the ack cycle, stb is still high then
   assign take = s_req.cyc && s_req.stb && !pend_q && !ack_q;

   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pend_q <= 1'b0;
         ack_q  <= 1'b0;
      end
      else
      begin
         pend_q <= take;
         // Access happens one edge after capture
         ack_q  <= pend_q;
      end
   end

   always_ff @(posedge Clk_100)
   begin
      if (take)
         req_q <= s_req;
   end

   // ============================================================
   // Memory access
   // ============================================================

   always_ff @(posedge Clk_100)
   begin
      if (pend_q)
      begin
         if (req_q.we)
         begin
            // Byte-lane write
            for (int b = 0; b < MEM_SEL_W; b++)
            begin
               if (req_q.sel[b])
                  mem[req_q.adr][b*8 +: 8] <= req_q.dat[b*8 +: 8];
            end
         end
         dat_q <= mem[req_q.adr];
      end
   end

   assign s_rsp.ack = ack_q;
   assign s_rsp.dat = dat_q;

endmodule

//--- hdl/wb_arbiter.sv
// Wishbone arbiter
// Round-robin between two masters, grant held for a whole bus cycle
`timescale 1ns/1ps

module wb_arbiter
(
   input  logic                   Clk_100,
   input  logic                   rst_n,
   input  mem_types_pkg::wb_req_t m0_req,
   input  mem_types_pkg::wb_req_t m1_req,
   output mem_types_pkg::wb_rsp_t m0_rsp,
   output mem_types_pkg::wb_rsp_t m1_rsp,
   output mem_types_pkg::wb_req_t s_req,
   input  mem_types_pkg::wb_rsp_t s_rsp
);

   // Registered grant, 0 = host bridge, 1 = copy engine
   logic gnt_q;
   // Master served by the last acknowledged cycle
   logic last_q;
   // Effective grant for this cycle
   logic sel;
   logic gnt_cyc;
   logic other_cyc;
   logic last_cyc;

   // ============================================================
   // Grant selection
   // ============================================================

   assign gnt_cyc   = gnt_q ? m1_req.cyc : m0_req.cyc;
   assign other_cyc = last_q ? m0_req.cyc : m1_req.cyc;
   assign last_cyc  = last_q ? m1_req.cyc : m0_req.cyc;

   // Decided in the same cycle so a free bus costs no extra cycle
   always_comb
   begin
      if (gnt_cyc)
         sel = gnt_q;
      else if (other_cyc)
         sel = ~last_q;
      else if (last_cyc)
         sel = last_q;
      else
         sel = gnt_q;
   end

   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         gnt_q  <= 1'b0;
         last_q <= 1'b1;
      end
      else
      begin
         gnt_q <= sel;
         if (s_rsp.ack)
            last_q <= sel;
      end
   end

   // ============================================================
   // Bus muxing
   // ============================================================

   assign s_req = sel ? m1_req : m0_req;

   // Ungranted master sees ack low and no data
   always_comb
   begin
      m0_rsp.ack = s_rsp.ack & ~sel;
      m0_rsp.dat = sel ? '0 : s_rsp.dat;
      m1_rsp.ack = s_rsp.ack & sel;
      m1_rsp.dat = sel ? s_rsp.dat : '0;
   end

endmodule

//--- hdl/copy_engine.sv
// Word copy engine
// Accelerator that moves a block of words over the shared bus, one read then one write
`timescale 1ns/1ps

module copy_engine
(
   input  logic                      Clk_100,
   input  logic                      rst_n,
   input  plat_types_pkg::copy_cmd_t copy_cmd,
   input  logic                      copy_cmd_valid,
   output logic                      copy_cmd_ready,
   output logic                      copy_done,
   output mem_types_pkg::wb_req_t    wb_m,
   input  mem_types_pkg::wb_rsp_t    wb_s
);

   import plat_types_pkg::*;
   import mem_types_pkg::*;

   typedef enum logic [1:0] {
      CP_IDLE,
      CP_READ,
      CP_WRITE,
      CP_FINISH
   } cp_state_e;

   cp_state_e             state_q;
   // Bus cycle in progress
   logic                  cyc_q;
   logic [MEM_ADDR_W-1:0] src_q;
   logic [MEM_ADDR_W-1:0] dst_q;
   // Words still to copy
   logic [COPY_CNT_W-1:0] cnt_q;
   // Word in flight between read and write
   logic [MEM_DATA_W-1:0] data_q;

   // ============================================================
   // Copy FSM
   // ============================================================

   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= CP_IDLE;
         cyc_q   <= 1'b0;
         src_q   <= '0;
         dst_q   <= '0;
         cnt_q   <= '0;
      end
      else
      begin
         case (state_q)
            CP_IDLE:
            begin
               if (copy_cmd_valid)
               begin
                  src_q   <= copy_cmd.src_adr;
                  dst_q   <= copy_cmd.dst_adr;
                  cnt_q   <= copy_cmd.count;
                  // Zero length goes straight to the done pulse
                  cyc_q   <= (copy_cmd.count != '0);
                  state_q <= (copy_cmd.count != '0) ? CP_READ : CP_FINISH;
               end
            end
            CP_READ:
            begin
               if (!cyc_q)
               begin
                  cyc_q <= 1'b1;
               end
               else if (wb_s.ack)
               begin
                  // cyc drops for one cycle so the arbiter may switch
                  cyc_q   <= 1'b0;
                  state_q <= CP_WRITE;
               end
            end
            CP_WRITE:
            begin
               if (!cyc_q)
               begin
                  cyc_q <= 1'b1;
               end
               else if (wb_s.ack)
               begin
                  cyc_q   <= 1'b0;
                  src_q   <= src_q + 1'b1;
                  dst_q   <= dst_q + 1'b1;
                  cnt_q   <= cnt_q - 1'b1;
                  state_q <= (cnt_q == COPY_CNT_W'(1)) ? CP_FINISH : CP_READ;
               end
            end
            CP_FINISH:
            begin
               state_q <= CP_IDLE;
            end
            default:
            begin
               state_q <= CP_IDLE;
            end
         endcase
      end
   end

   // Read data holding register
   always_ff @(posedge Clk_100)
   begin
      if (state_q == CP_READ && cyc_q && wb_s.ack)
         data_q <= wb_s.dat;
   end

   // ============================================================
   // Outputs
   // ============================================================

   assign copy_cmd_ready = (state_q == CP_IDLE);
   assign copy_done      = (state_q == CP_FINISH);

   // Destination writes always use all byte lanes
   always_comb
   begin
      wb_m.cyc = cyc_q;
      wb_m.stb = cyc_q;
      wb_m.we  = (state_q == CP_WRITE);
      wb_m.adr = (state_q == CP_WRITE) ? dst_q : src_q;
      wb_m.dat = data_q;
      wb_m.sel = '1;
   end

endmodule

//--- hdl/host_mmio_bridge.sv
// Host MMIO bridge
// Turns one host request at a time into a Wishbone classic cycle
`timescale 1ns/1ps

module host_mmio_bridge
(
   input  logic                     Clk_100,
   input  logic                     rst_n,
   input  plat_types_pkg::host_req_t host_req,
   input  logic                     host_req_valid,
   output logic                     host_req_ready,
   output plat_types_pkg::host_rsp_t host_rsp,
   output mem_types_pkg::wb_req_t   wb_m,
   input  mem_types_pkg::wb_rsp_t   wb_s
);

   import plat_types_pkg::*;
   import mem_types_pkg::*;

   typedef enum logic [1:0] {
      HB_IDLE,
      HB_BUS,
      HB_RESP
   } hb_state_e;

   hb_state_e             state_q;
   // Latched request, payload only
   host_req_t             req_q;
   // Read data captured on ack
   logic [MEM_DATA_W-1:0] rd_q;

   // ============================================================
   // Control FSM
   // ============================================================

   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= HB_IDLE;
      end
      else
      begin
         case (state_q)
            HB_IDLE:
            begin
               if (host_req_valid)
                  state_q <= HB_BUS;
            end
            HB_BUS:
            begin
               // Dropping out of HB_BUS releases cyc/stb right after ack
               if (wb_s.ack)
                  state_q <= HB_RESP;
            end
            HB_RESP:
            begin
               state_q <= HB_IDLE;
            end
            default:
            begin
               state_q <= HB_IDLE;
            end
         endcase
      end
   end

   // Request latch and read data capture
   always_ff @(posedge Clk_100)
   begin
      if (state_q == HB_IDLE && host_req_valid)
         req_q <= host_req;
      if (state_q == HB_BUS && wb_s.ack)
      begin
         // Writes return zero data
         rd_q <= (req_q.op == HOST_WRITE) ? '0 : wb_s.dat;
      end
   end

   // ============================================================
   // Outputs
   // ============================================================

   assign host_req_ready = (state_q == HB_IDLE);

   // Bus signals follow the state, stable for the whole cycle
   always_comb
   begin
      wb_m.cyc = (state_q == HB_BUS);
      wb_m.stb = (state_q == HB_BUS);
      wb_m.we  = (req_q.op == HOST_WRITE);
      wb_m.adr = req_q.adr;
      wb_m.dat = req_q.dat;
      wb_m.sel = req_q.sel;
   end

   assign host_rsp.valid = (state_q == HB_RESP);
   assign host_rsp.dat   = rd_q;

endmodule

//--- hdl/reset_resync.sv
// Reset synchronizer
// Asserts asynchronously, releases on a Clk_100 edge after a short flop chain
`timescale 1ns/1ps

module reset_resync
(
   input  logic Clk_100,
   input  logic rst_n,
   output logic rst_sync_n
);

   import mem_types_pkg::*;

   // Shift chain, all zeros while in reset
   logic [RST_SYNC_LEN-1:0] sync_q;

   // Ones shift in from bit 0 once rst_n is high
   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sync_q <= '0;
      end
      else
      begin
         sync_q <= {sync_q[RST_SYNC_LEN-2:0], 1'b1};
      end
   end

   // Last stage drives the internal reset
   assign rst_sync_n = sync_q[RST_SYNC_LEN-1];

endmodule

//--- hdl/plat_types_pkg.sv
// Platform channel types
// Host MMIO request/response and copy command formats for the shell
package plat_types_pkg;

   // Copy length field width, in words
   localparam int COPY_CNT_W = 8;

   // ============================================================
   // Host channel
   // ============================================================

   // Host operation code
   typedef enum logic {
      HOST_READ  = 1'b0,
      HOST_WRITE = 1'b1
   } host_op_e;

   // One MMIO request, word addressed
   typedef struct packed {
      host_op_e                                op;
      logic [mem_types_pkg::MEM_ADDR_W-1:0]    adr;
      logic [mem_types_pkg::MEM_DATA_W-1:0]    dat;
      logic [mem_types_pkg::MEM_SEL_W-1:0]     sel;
   } host_req_t;

   // Result, valid for exactly one cycle
   // Data is zero for writes
   typedef struct packed {
      logic                                    valid;
      logic [mem_types_pkg::MEM_DATA_W-1:0]    dat;
   } host_rsp_t;

   // ============================================================
   // Accelerator command
   // ============================================================

   // Block copy from src_adr to dst_adr, count words
   typedef struct packed {
      logic [mem_types_pkg::MEM_ADDR_W-1:0]    src_adr;
      logic [mem_types_pkg::MEM_ADDR_W-1:0]    dst_adr;
      logic [COPY_CNT_W-1:0]                   count;
   } copy_cmd_t;

endpackage

//--- hdl/mem_types_pkg.sv
// Local memory bus types
// Wishbone classic request/response structs and memory bank geometry
package mem_types_pkg;

   // ============================================================
   // Memory bank geometry
   // ============================================================

   // Word address width, one bank of 256 words
   localparam int MEM_ADDR_W   = 8;
   localparam int MEM_DATA_W   = 32;
   // One select bit per byte lane
   localparam int MEM_SEL_W    = 4;
   localparam int MEM_DEPTH    = 256;

   // Flop stages in the internal reset synchronizer
   localparam int RST_SYNC_LEN = 2;

   // ============================================================
   // Wishbone classic structs
   // ============================================================

   // Master to slave, held stable from stb rise until ack
   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [MEM_ADDR_W-1:0] adr;
      logic [MEM_DATA_W-1:0] dat;
      logic [MEM_SEL_W-1:0]  sel;
   } wb_req_t;

   // Slave to master, ack is a single-cycle strobe
   typedef struct packed {
      logic                  ack;
      logic [MEM_DATA_W-1:0] dat;
   } wb_rsp_t;

endpackage
